//--- common/demodPkg.sv
package demodPkg;

  // ****************************************
  // vector types
  // ****************************************
  typedef logic signed [17:0] sample_t;  // demod or trellis sample
  typedef logic [13:0] dacWord_t;        // one DAC word
  typedef logic [11:0] regAddr_t;        // processor word address
  typedef logic [15:0] regData_t;
  typedef logic [1:0] selCode_t;         // routing select field

  // demodulator mode, only the codes the output core decodes
  typedef enum logic [4:0] {
    MODE_OTHER      = 5'd0,
    MODE_AQPSK      = 5'd3,
    MODE_AUQPSK     = 5'd4,
    MODE_PCMTRELLIS = 5'd8,
    MODE_SOQPSK     = 5'd9
  } demodMode_t;

  // per-channel monitor select
  typedef enum logic [3:0] {
    DAC_DEMOD_DEFAULT = 4'h0,
    DAC_TRELLIS_I     = 4'h8,
    DAC_TRELLIS_Q     = 4'h9,
    DAC_TRELLIS_PHERR = 4'ha,
    DAC_TRELLIS_INDEX = 4'hb
  } dacSelect_t;

  // ****************************************
  // bundles
  // ****************************************
  typedef struct packed {
    sample_t sample;
    logic    valid;  // sample strobe
  } sampleStrobe_t;

  typedef struct packed {
    logic iBit;
    logic qBit;
    logic symEn;    // symbol rate enable
    logic sym2xEn;  // twice symbol rate
  } bitStrobe_t;

  typedef struct packed {
    logic     we;
    logic     re;
    regAddr_t addr;
    regData_t wdata;
  } cpuBus_t;

  typedef struct packed {
    selCode_t [2:0] dacInSel;  // dac0 in the low field
    selCode_t       decInSel;
    selCode_t       qOutSel;
  } routeCfg_t;

  // ****************************************
  // register map and codes
  // ****************************************
  localparam regAddr_t ADDR_VERSION    = 12'h000;
  localparam regAddr_t ADDR_TYPE       = 12'h002;
  localparam regAddr_t ADDR_DAC_IN_SEL = 12'h004;
  localparam regAddr_t ADDR_DEC_IN_SEL = 12'h006;
  localparam regAddr_t ADDR_RESET      = 12'h008;

  localparam regData_t IMAGE_TYPE = 16'h0006;  // trellis demod image

  localparam selCode_t SEL_DEMOD = 2'd0;
  localparam selCode_t SEL_SC    = 2'd1;  // subcarrier path

endpackage

//--- design/regBank.sv
module regBank #(
  parameter demodPkg::regData_t VerNumber = 16'd431
) (
  input  logic                clk,
  input  logic                rs,
  input  demodPkg::cpuBus_t   cpu_i,
  output demodPkg::regData_t  cpuRData_o,
  output demodPkg::routeCfg_t cfg_o,
  output logic                softResetReq_o
);
  import demodPkg::*;

  routeCfg_t   cfg;
  regData_t    rdData;
  regData_t    rdMux;
  logic [31:0] cfgWord;

  // 32-bit routing word as the two halves are laid out on the bus
  //   [31:16]  qOutSel at 21:20, decInSel at 17:16
  //   [15:0]   dac2/dac1/dac0 selects in 5:0
  // bits 19:18 stay zero, the old I output select lived there
  assign cfgWord = {10'b0, cfg.qOutSel, 2'b00, cfg.decInSel,
                    10'b0, cfg.dacInSel};

  // ****************************************
  // register writes
  // ****************************************
  always_ff @(posedge clk or posedge rs) begin
    if (rs) begin
      cfg <= '0;  // only pin reset, routing survives soft reset
    end else if (cpu_i.we) begin
      case (cpu_i.addr)
        ADDR_DAC_IN_SEL: begin
          cfg.dacInSel <= cpu_i.wdata[5:0];
        end
        ADDR_DEC_IN_SEL: begin
          cfg.decInSel <= cpu_i.wdata[1:0];
          cfg.qOutSel  <= cpu_i.wdata[5:4];
        end
        default: ;
      endcase
    end
  end

  // soft reset request, one clock wide since we is a pulse
  assign softResetReq_o = cpu_i.we && (cpu_i.addr == ADDR_RESET);

  // ****************************************
  // read mux
  // ****************************************
  always_comb begin
    case (cpu_i.addr)
      ADDR_VERSION: begin
        rdMux = VerNumber;
      end
      ADDR_TYPE: begin
        rdMux = IMAGE_TYPE;
      end
      ADDR_DAC_IN_SEL,
      ADDR_DEC_IN_SEL: begin
        // addr bit 1 picks the upper half
        rdMux = cpu_i.addr[1] ? cfgWord[31:16] : cfgWord[15:0];
      end
      default: begin
        rdMux = '0;  // unmapped
      end
    endcase
  end

  // read data lands one clock after re and holds
  always_ff @(posedge clk or posedge rs) begin
    if (rs) begin
      rdData <= '0;
    end else if (cpu_i.re) begin
      rdData <= rdMux;
    end
  end

  assign cpuRData_o = rdData;
  assign cfg_o      = cfg;

endmodule

//--- design/resetStretch.sv
module resetStretch #(
  parameter int ResetHold = 6
) (
  input  logic clk,
  input  logic rs,
  input  logic softResetReq_i,
  output logic coreReset_o
);

  localparam int CntW = $clog2(ResetHold + 1);

  logic [CntW-1:0] holdCnt;  // clocks of reset left
  logic            holdRst;  // registered so the reset net is glitch free

  // request is taken on the clock edge that loads the counter
  always_ff @(posedge clk or posedge rs) begin
    if (rs) begin
      holdCnt <= '0;
      holdRst <= 1'b0;
    end else if (softResetReq_i) begin
      holdCnt <= CntW'(ResetHold);
      holdRst <= 1'b1;
    end else if (holdCnt != '0) begin
      holdCnt <= holdCnt - 1'b1;
      holdRst <= (holdCnt > CntW'(1));  // drops as the count hits zero
    end
  end

  // pin reset also shows on the output
  assign coreReset_o = rs || holdRst;

endmodule

//--- dacPath/dacSourceSelect.sv
module dacSourceSelect #(
  parameter int NumDac = 3
) (
  input  logic                    clk,
  input  logic                    coreReset_i,
  input  demodPkg::routeCfg_t     cfg_i,
  input  demodPkg::demodMode_t    demodMode_i,
  input  demodPkg::dacSelect_t    dacSelect_i [NumDac],
  input  demodPkg::sampleStrobe_t demodSample_i [NumDac],
  input  demodPkg::sampleStrobe_t trellisSample_i [NumDac],
  input  demodPkg::sampleStrobe_t scSample_i [NumDac],
  output demodPkg::sampleStrobe_t selSample_o [NumDac]
);
  import demodPkg::*;

  // capture stage
  sample_t           capDemod [NumDac];
  sample_t           capTrellis [NumDac];
  sample_t           capSc [NumDac];
  logic [NumDac-1:0] capDemodVld;
  logic [NumDac-1:0] capTrellisVld;
  logic [NumDac-1:0] capScVld;
  dacSelect_t        capSel [NumDac];
  demodMode_t        capMode;
  logic              trellisMode;
  // select stage
  logic [NumDac-1:0] useSc;
  logic [NumDac-1:0] useTrellis;
  sample_t           selData [NumDac];
  logic [NumDac-1:0] selVld;

  // ****************************************
  // capture
  // ****************************************
  always_ff @(posedge clk or posedge coreReset_i) begin
    if (coreReset_i) begin
      capDemodVld   <= '0;
      capTrellisVld <= '0;
      capScVld      <= '0;
    end else begin
      for (int ch = 0; ch < NumDac; ch++) begin
        capDemodVld[ch]   <= demodSample_i[ch].valid;
        capTrellisVld[ch] <= trellisSample_i[ch].valid;
        capScVld[ch]      <= scSample_i[ch].valid;
      end
    end
  end

  always_ff @(posedge clk) begin
    capMode <= demodMode_i;
    for (int ch = 0; ch < NumDac; ch++) begin
      capDemod[ch]   <= demodSample_i[ch].sample;
      capTrellis[ch] <= trellisSample_i[ch].sample;
      capSc[ch]      <= scSample_i[ch].sample;
      capSel[ch]     <= dacSelect_i[ch];
    end
  end

  assign trellisMode = capMode inside {MODE_PCMTRELLIS, MODE_SOQPSK};

  // ****************************************
  // source select
  // ****************************************
  always_comb begin
    for (int ch = 0; ch < NumDac; ch++) begin
      useSc[ch] = (cfg_i.dacInSel[ch] == SEL_SC);
      // trellis monitor only when the trellis is running and asked for
      useTrellis[ch] = (cfg_i.dacInSel[ch] == SEL_DEMOD) && trellisMode &&
                       (capSel[ch] inside {DAC_TRELLIS_I, DAC_TRELLIS_Q,
                                           DAC_TRELLIS_PHERR, DAC_TRELLIS_INDEX});
    end
  end

  always_ff @(posedge clk or posedge coreReset_i) begin
    if (coreReset_i) begin
      selVld <= '0;
    end else begin
      for (int ch = 0; ch < NumDac; ch++) begin
        selVld[ch] <= useSc[ch]      ? capScVld[ch] :
                      useTrellis[ch] ? capTrellisVld[ch] : capDemodVld[ch];
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int ch = 0; ch < NumDac; ch++) begin
      selData[ch] <= useSc[ch]      ? capSc[ch] :
                     useTrellis[ch] ? capTrellis[ch] : capDemod[ch];
    end
  end

  always_comb begin
    for (int ch = 0; ch < NumDac; ch++) begin
      selSample_o[ch].sample = selData[ch];
      selSample_o[ch].valid  = selVld[ch];
    end
  end

endmodule

//--- dacPath/dacFormat.sv
module dacFormat #(
  parameter int NumDac = 3
) (
  input  logic                    clk,
  input  logic                    coreReset_i,
  input  demodPkg::sampleStrobe_t selSample_i [NumDac],
  output demodPkg::dacWord_t      dacData_o [NumDac],
  output logic [NumDac-1:0]       dacValid_o
);
  import demodPkg::*;

  dacWord_t offsetWord [NumDac];

  // top 14 bits, MSB flipped gives offset binary for the DAC
  always_comb begin
    for (int ch = 0; ch < NumDac; ch++) begin
      offsetWord[ch] = {~selSample_i[ch].sample[17], selSample_i[ch].sample[16:4]};
    end
  end

  // ****************************************
  // output register
  // ****************************************
  always_ff @(posedge clk or posedge coreReset_i) begin
    if (coreReset_i) begin
      dacValid_o <= '0;
    end else begin
      for (int ch = 0; ch < NumDac; ch++) begin
        dacValid_o[ch] <= selSample_i[ch].valid;
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int ch = 0; ch < NumDac; ch++) begin
      if (selSample_i[ch].valid) begin
        dacData_o[ch] <= offsetWord[ch];  // held between strobes
      end
    end
  end

endmodule

//--- design/bitSelect.sv
module bitSelect (
  input  logic                 clk,
  input  logic                 coreReset_i,
  input  demodPkg::routeCfg_t  cfg_i,
  input  demodPkg::demodMode_t demodMode_i,
  input  demodPkg::bitStrobe_t demodBits_i,
  input  demodPkg::bitStrobe_t trellisBits_i,
  input  demodPkg::bitStrobe_t scBits_i,
  input  logic                 auQBit_i,
  output demodPkg::bitStrobe_t decBits_o,
  output logic                 qOut_o
);
  import demodPkg::*;

  bitStrobe_t fixedTrellis;
  bitStrobe_t capDemod;
  bitStrobe_t capSc;
  bitStrobe_t decSel;
  demodMode_t capMode;
  logic       capAuQ;
  logic       trellisMode;
  logic       auMode;
  logic       qSel;

  assign trellisMode = demodMode_i inside {MODE_PCMTRELLIS, MODE_SOQPSK};

  // trellis decision comes out inverted, one bit feeds both rails
  always_comb begin
    fixedTrellis      = trellisBits_i;
    fixedTrellis.iBit = ~trellisBits_i.iBit;
    fixedTrellis.qBit = ~trellisBits_i.iBit;
  end

  // ****************************************
  // capture
  // ****************************************
  always_ff @(posedge clk or posedge coreReset_i) begin
    if (coreReset_i) begin
      capDemod <= '0;
      capSc    <= '0;
      capAuQ   <= 1'b0;
      capMode  <= MODE_OTHER;
    end else begin
      capDemod <= trellisMode ? fixedTrellis : demodBits_i;
      capSc    <= scBits_i;
      capAuQ   <= auQBit_i;
      capMode  <= demodMode_i;
    end
  end

  assign auMode = capMode inside {MODE_AQPSK, MODE_AUQPSK};
  assign decSel = (cfg_i.decInSel == SEL_SC) ? capSc : capDemod;

  // Q output: subcarrier, then the AU path, else whatever feeds the decoder
  assign qSel = (cfg_i.qOutSel == SEL_SC) ? capSc.qBit :
                auMode                    ? capAuQ : decSel.qBit;

  // ****************************************
  // select
  // ****************************************
  always_ff @(posedge clk or posedge coreReset_i) begin
    if (coreReset_i) begin
      decBits_o <= '0;
      qOut_o    <= 1'b0;
    end else begin
      decBits_o <= decSel;
      qOut_o    <= qSel;
    end
  end

endmodule

//--- design/demodOutTop.sv
module demodOutTop #(
  parameter int                 NumDac    = 3,
  parameter demodPkg::regData_t VerNumber = 16'd431,
  parameter int                 ResetHold = 6
) (
  input  logic                    clk,
  input  logic                    rs,
  input  demodPkg::cpuBus_t       cpu_i,
  input  demodPkg::demodMode_t    demodMode_i,
  input  demodPkg::dacSelect_t    dacSelect_i [NumDac],
  input  demodPkg::sampleStrobe_t demodSample_i [NumDac],
  input  demodPkg::sampleStrobe_t trellisSample_i [NumDac],
  input  demodPkg::sampleStrobe_t scSample_i [NumDac],
  input  demodPkg::bitStrobe_t    demodBits_i,
  input  demodPkg::bitStrobe_t    trellisBits_i,
  input  demodPkg::bitStrobe_t    scBits_i,
  input  logic                    auQBit_i,
  output demodPkg::regData_t      cpuRData_o,
  output demodPkg::dacWord_t      dacData_o [NumDac],
  output logic [NumDac-1:0]       dacValid_o,
  output demodPkg::bitStrobe_t    decBits_o,
  output logic                    qOut_o,
  output logic                    dacRst_o
);
  import demodPkg::*;

  routeCfg_t     cfg;
  logic          softResetReq;
  logic          stretchReset;
  logic          coreReset;     // clears pipeline strobes
  sampleStrobe_t selSample [NumDac];

  // ****************************************
  // control
  // ****************************************
  regBank #(.VerNumber(VerNumber)) uRegBank (
    .clk            (clk),
    .rs             (rs),
    .cpu_i          (cpu_i),
    .cpuRData_o     (cpuRData_o),
    .cfg_o          (cfg),
    .softResetReq_o (softResetReq)
  );

  resetStretch #(.ResetHold(ResetHold)) uResetStretch (
    .clk            (clk),
    .rs             (rs),
    .softResetReq_i (softResetReq),
    .coreReset_o    (stretchReset)
  );

  assign coreReset = rs || stretchReset;
  assign dacRst_o  = coreReset;  // DACs reset with the core

  // ****************************************
  // DAC path, capture/select then format
  // ****************************************
  dacSourceSelect #(.NumDac(NumDac)) uDacSourceSelect (
    .clk             (clk),
    .coreReset_i     (coreReset),
    .cfg_i           (cfg),
    .demodMode_i     (demodMode_i),
    .dacSelect_i     (dacSelect_i),
    .demodSample_i   (demodSample_i),
    .trellisSample_i (trellisSample_i),
    .scSample_i      (scSample_i),
    .selSample_o     (selSample)
  );

  dacFormat #(.NumDac(NumDac)) uDacFormat (
    .clk         (clk),
    .coreReset_i (coreReset),
    .selSample_i (selSample),
    .dacData_o   (dacData_o),
    .dacValid_o  (dacValid_o)
  );

  // decoder bits and Q output
  bitSelect uBitSelect (
    .clk           (clk),
    .coreReset_i   (coreReset),
    .cfg_i         (cfg),
    .demodMode_i   (demodMode_i),
    .demodBits_i   (demodBits_i),
    .trellisBits_i (trellisBits_i),
    .scBits_i      (scBits_i),
    .auQBit_i      (auQBit_i),
    .decBits_o     (decBits_o),
    .qOut_o        (qOut_o)
  );

endmodule

//--- dv/demodOut_assertions.sv
module demodOut_assertions #(
  parameter int ResetHold = 6
) (
  input logic                 clk,
  input logic                 rs,
  input logic                 dacRst_o,
  input logic                 we,
  input logic                 re,
  input demodPkg::selCode_t   dacInSel0,
  input demodPkg::dacSelect_t dacSelect0,
  input logic                 demodVld0,
  input logic                 dacValid0
);
  timeunit 1ns;
  timeprecision 1ps;
  import demodPkg::*;

  logic demodPicked;  // channel 0 fixed on the demod sample

  assign demodPicked = (dacInSel0 == SEL_DEMOD) && (dacSelect0 == DAC_DEMOD_DEFAULT);

  // ****************************************
  // properties
  // ****************************************
  resetLength: assert property (@(posedge clk)
    ($rose(dacRst_o) && !rs) |-> dacRst_o[*ResetHold] ##1 !dacRst_o)
    else $error("dacRst_o length differs from ResetHold");

  validDelay: assert property (@(posedge clk)
    (demodPicked && !dacRst_o)[*4] |-> (dacValid0 == $past(demodVld0, 3)))
    else $error("dacValid_o does not follow demod valid");

  busExclusive: assert property (@(posedge clk) !(we && re))
    else $error("cpu we and re high together");

endmodule

bind demodOutTop demodOut_assertions #(.ResetHold(ResetHold)) uAssertions (
  .clk        (clk),
  .rs         (rs),
  .dacRst_o   (dacRst_o),
  .we         (cpu_i.we),
  .re         (cpu_i.re),
  .dacInSel0  (cfg.dacInSel[0]),
  .dacSelect0 (dacSelect_i[0]),
  .demodVld0  (demodSample_i[0].valid),
  .dacValid0  (dacValid_o[0])
);

//--- dv/demodOutTb.sv
module demodOutTb;
  timeunit 1ns;
  timeprecision 1ps;
  import demodPkg::*;

  localparam int NumDac    = 3;
  localparam int ResetHold = 6;
  localparam int MaxLen    = 64;

  logic          clk;
  logic          rs;
  cpuBus_t       cpu;
  demodMode_t    mode;
  dacSelect_t    dacSel [NumDac];
  sampleStrobe_t demodS [NumDac];
  sampleStrobe_t trellisS [NumDac];
  sampleStrobe_t scS [NumDac];
  bitStrobe_t    demodB;
  bitStrobe_t    trellisB;
  bitStrobe_t    scB;
  logic          auQ;
  regData_t      rData;
  dacWord_t      dacData [NumDac];
  logic [NumDac-1:0] dacValid;
  bitStrobe_t    decBits;
  logic          qOut;
  logic          dacRst;

  logic [31:0] rngState = 32'h58ae_489f;
  selCode_t    chSel [NumDac];  // routing under test
  dacWord_t    expWord [MaxLen][NumDac];
  logic        expVld [MaxLen][NumDac];
  dacWord_t    lastWord [NumDac];
  bitStrobe_t  expDec [MaxLen];
  logic        expQ [MaxLen];

  demodOutTop #(.NumDac(NumDac), .VerNumber(16'd431), .ResetHold(ResetHold)) DUT (
    .clk (clk), .rs (rs), .cpu_i (cpu), .demodMode_i (mode), .dacSelect_i (dacSel),
    .demodSample_i (demodS), .trellisSample_i (trellisS), .scSample_i (scS),
    .demodBits_i (demodB), .trellisBits_i (trellisB), .scBits_i (scB), .auQBit_i (auQ),
    .cpuRData_o (rData), .dacData_o (dacData), .dacValid_o (dacValid),
    .decBits_o (decBits), .qOut_o (qOut), .dacRst_o (dacRst)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ****************************************
  // helpers
  // ****************************************
  function logic [31:0] nextRand();
    rngState = rngState ^ (rngState << 13);
    rngState = rngState ^ (rngState >> 17);
    rngState = rngState ^ (rngState << 5);
    return rngState;
  endfunction

  function logic randBit();
    logic [31:0] r;
    r = nextRand();
    return r[7];
  endfunction

  task stopOnError(string msg);
    $display("%s", msg);
    $display("Result: FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task compareData(string name, regData_t exp, regData_t act);
    if (exp !== act) stopOnError($sformatf("[FAIL] %s expected %h actual %h", name, exp, act));
  endtask

  task compareDac(string name, dacWord_t exp, dacWord_t act);
    if (exp !== act) stopOnError($sformatf("[FAIL] %s expected %h actual %h", name, exp, act));
  endtask

  task compareBits(string name, bitStrobe_t exp, bitStrobe_t act);
    if (exp !== act) stopOnError($sformatf("[FAIL] %s expected %b actual %b", name, exp, act));
  endtask

  task writeReg(regAddr_t a, regData_t d);
    @(posedge clk);
    cpu <= {1'b1, 1'b0, a, d};
    @(posedge clk);
    cpu.we <= 1'b0;
  endtask

  task readReg(regAddr_t a, output regData_t d);
    @(posedge clk);
    cpu <= {1'b0, 1'b1, a, 16'h0};
    @(posedge clk);
    cpu.re <= 1'b0;
    @(negedge clk);  // data is one clock after re
    d = rData;
  endtask

  // source code per channel is 0 demod, 1 trellis or 2 subcarrier
  function int srcOf(selCode_t s, demodMode_t m, dacSelect_t d);
    if (s == SEL_SC) return 2;
    if (s == SEL_DEMOD && (m == MODE_PCMTRELLIS || m == MODE_SOQPSK) &&
        (d == DAC_TRELLIS_I || d == DAC_TRELLIS_Q || d == DAC_TRELLIS_PHERR ||
         d == DAC_TRELLIS_INDEX)) return 1;
    return 0;
  endfunction

  // upper 14 bits in offset binary
  function dacWord_t toDac(sample_t s);
    return dacWord_t'(s >>> 4) ^ 14'h2000;
  endfunction

  // ****************************************
  // directed tests
  // ****************************************
  task testRegisters();
    regData_t d;
    readReg(ADDR_VERSION, d);
    compareData("version", 16'd431, d);
    readReg(ADDR_TYPE, d);
    compareData("type", IMAGE_TYPE, d);
    writeReg(ADDR_DAC_IN_SEL, 16'hffd6);
    readReg(ADDR_DAC_IN_SEL, d);
    compareData("dacInSel readback", 16'hffd6 & 16'h003f, d);
    writeReg(ADDR_DEC_IN_SEL, 16'hfff2);
    readReg(ADDR_DEC_IN_SEL, d);
    compareData("decInSel readback", 16'hfff2 & 16'h0033, d);
    readReg(12'h00a, d);
    compareData("unmapped read", 16'h0000, d);
  endtask

  task testSoftReset();
    regData_t d;
    int       wait0;
    int       hi;
    writeReg(ADDR_DAC_IN_SEL, 16'h0019);
    writeReg(ADDR_RESET, 16'h0001);
    wait0 = 0;
    @(negedge clk);
    while (!dacRst && wait0 < 10) begin  // bounded wait for the rise
      wait0++;
      @(negedge clk);
    end
    if (!dacRst) stopOnError("soft reset never raised dacRst_o");
    compareData("soft reset start", 16'd0, regData_t'(wait0));
    hi = 0;
    while (dacRst && hi < 50) begin
      hi++;
      @(negedge clk);
    end
    compareData("soft reset length", regData_t'(ResetHold), regData_t'(hi));
    readReg(ADDR_DAC_IN_SEL, d);
    compareData("routing kept", 16'h0019, d);
  endtask

  task runDacScenario(string name, demodMode_t m, selCode_t s0, selCode_t s1, selCode_t s2,
                      dacSelect_t d0, dacSelect_t d1, dacSelect_t d2, int n, bit randVld);
    sampleStrobe_t pick;
    int            src;
    chSel[0] = s0;
    chSel[1] = s1;
    chSel[2] = s2;
    writeReg(ADDR_DAC_IN_SEL, {10'b0, s2, s1, s0});
    mode <= m;
    dacSel[0] <= d0;
    dacSel[1] <= d1;
    dacSel[2] <= d2;
    for (int t = 0; t < n + 3; t++) begin
      @(posedge clk);
      for (int ch = 0; ch < NumDac; ch++) begin
        if (t < n) begin
          demodS[ch]   <= {sample_t'(nextRand()), (t == 0) || !randVld || randBit()};
          trellisS[ch] <= {sample_t'(nextRand()), (t == 0) || !randVld || randBit()};
          scS[ch]      <= {sample_t'(nextRand()), (t == 0) || !randVld || randBit()};
        end else begin
          demodS[ch].valid   <= 1'b0;  // idle after the burst
          trellisS[ch].valid <= 1'b0;
          scS[ch].valid      <= 1'b0;
        end
      end
      #1;  // look at what was just driven
      if (t < n) begin
        for (int ch = 0; ch < NumDac; ch++) begin
          src  = srcOf(chSel[ch], m, dacSel[ch]);
          pick = (src == 2) ? scS[ch] : (src == 1) ? trellisS[ch] : demodS[ch];
          if (pick.valid) lastWord[ch] = toDac(pick.sample);
          expWord[t][ch] = lastWord[ch];
          expVld[t][ch]  = pick.valid;
        end
      end
      @(negedge clk);
      if (t >= 3) begin
        for (int ch = 0; ch < NumDac; ch++) begin
          compareDac($sformatf("%s ch%0d word", name, ch), expWord[t-3][ch], dacData[ch]);
          compareBits($sformatf("%s ch%0d valid", name, ch),
                      bitStrobe_t'(expVld[t-3][ch]), bitStrobe_t'(dacValid[ch]));
        end
      end
    end
  endtask

  task runBitScenario(string name, demodMode_t m, selCode_t dec, selCode_t qs, int n);
    bitStrobe_t fixd;
    bitStrobe_t sel;
    writeReg(ADDR_DEC_IN_SEL, {10'b0, qs, 2'b00, dec});
    mode <= m;
    for (int t = 0; t < n + 2; t++) begin
      @(posedge clk);
      demodB   <= bitStrobe_t'(nextRand());
      trellisB <= bitStrobe_t'(nextRand());
      scB      <= bitStrobe_t'(nextRand());
      auQ      <= randBit();
      #1;
      if (m == MODE_PCMTRELLIS || m == MODE_SOQPSK) begin
        fixd      = trellisB;
        fixd.iBit = ~trellisB.iBit;  // inverted trellis bit on both rails
        fixd.qBit = ~trellisB.iBit;
      end else begin
        fixd = demodB;
      end
      sel = (dec == SEL_SC) ? scB : fixd;
      expDec[t] = sel;
      if (qs == SEL_SC) expQ[t] = scB.qBit;
      else if (m == MODE_AQPSK || m == MODE_AUQPSK) expQ[t] = auQ;
      else expQ[t] = sel.qBit;
      @(negedge clk);
      if (t >= 2) begin
        compareBits({name, " decBits"}, expDec[t-2], decBits);
        compareBits({name, " qOut"}, bitStrobe_t'(expQ[t-2]), bitStrobe_t'(qOut));
      end
    end
  endtask

  // ****************************************
  // main sequence
  // ****************************************
  initial begin
    rs       = 1'b1;
    cpu      = '0;
    mode     = MODE_OTHER;
    demodB   = '0;
    trellisB = '0;
    scB      = '0;
    auQ      = 1'b0;
    for (int ch = 0; ch < NumDac; ch++) begin
      dacSel[ch]   = DAC_DEMOD_DEFAULT;
      demodS[ch]   = '0;
      trellisS[ch] = '0;
      scS[ch]      = '0;
    end
    repeat (16) @(posedge clk);
    rs <= 1'b0;
    testRegisters();
    testSoftReset();
    runDacScenario("dac mixA", MODE_PCMTRELLIS, SEL_SC, SEL_DEMOD, SEL_DEMOD,
                   DAC_TRELLIS_I, DAC_TRELLIS_PHERR, DAC_DEMOD_DEFAULT, 20, 1'b0);
    runDacScenario("dac mixB", MODE_AQPSK, SEL_DEMOD, SEL_DEMOD, SEL_DEMOD,
                   DAC_TRELLIS_Q, DAC_TRELLIS_I, DAC_TRELLIS_INDEX, 20, 1'b0);
    runDacScenario("dac mixC", MODE_SOQPSK, SEL_DEMOD, SEL_SC, SEL_DEMOD,
                   DAC_TRELLIS_INDEX, DAC_DEMOD_DEFAULT, DAC_TRELLIS_Q, 20, 1'b0);
    runDacScenario("dac valid", MODE_OTHER, SEL_DEMOD, SEL_SC, SEL_SC,
                   DAC_DEMOD_DEFAULT, DAC_TRELLIS_I, DAC_TRELLIS_I, 40, 1'b1);
    runBitScenario("bits trellis", MODE_PCMTRELLIS, SEL_DEMOD, SEL_DEMOD, 16);
    runBitScenario("bits sc", MODE_SOQPSK, SEL_SC, SEL_DEMOD, 16);
    runBitScenario("bits aqpsk", MODE_AQPSK, SEL_DEMOD, SEL_DEMOD, 16);
    runBitScenario("bits qsc", MODE_AUQPSK, SEL_DEMOD, SEL_SC, 16);
    runBitScenario("bits other", MODE_OTHER, SEL_DEMOD, SEL_DEMOD, 16);
    $display("Result: PASSED");
    $finish;
  end

endmodule

//--- list.f
common/demodPkg.sv
design/regBank.sv
design/resetStretch.sv
dacPath/dacSourceSelect.sv
dacPath/dacFormat.sv
design/bitSelect.sv
design/demodOutTop.sv
dv/demodOut_assertions.sv
dv/demodOutTb.sv

//--- Makefile
# Verilator build for the demod output core testbench

VERILATOR ?= verilator
TOP       ?= demodOutTb
FLIST     ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wall

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: compile
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi
	@if ! grep -q "Result: PASSED" $(LOG); then \
		echo "simulation ended without passing"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
